// File: testbench/encoderInput.dat
// kind_pad_field_value: 1 message start (field 1 = random delays), 2 symbol and repeat count,
// 3 expected word with valid byte count, f end; messages without kind 3 use the reference coder
// end of message alone: eight ones then one zero
1_000_0000_00000000
2_000_0100_00000001
3_000_0002_000000ff
// short text, no delays
1_000_0000_00000000
2_000_0048_00000001
2_000_0065_00000001
2_000_006c_00000002
2_000_006f_00000001
2_000_002c_00000001
2_000_0020_00000001
2_000_0077_00000001
2_000_006f_00000001
2_000_0072_00000001
2_000_006c_00000001
2_000_0064_00000001
2_000_0021_00000001
2_000_0100_00000001
// same text again with random delays, must start from the uniform model
1_000_0001_00000000
2_000_0048_00000001
2_000_0065_00000001
2_000_006c_00000002
2_000_006f_00000001
2_000_002c_00000001
2_000_0020_00000001
2_000_0077_00000001
2_000_006f_00000001
2_000_0072_00000001
2_000_006c_00000001
2_000_0064_00000001
2_000_0021_00000001
2_000_0100_00000001
// long run of one byte, crosses the halving limit
1_000_0000_00000000
2_000_0061_0000076c
2_000_0100_00000001
// mixed runs with random delays
1_000_0001_00000000
2_000_0078_00000028
2_000_0079_00000019
2_000_0000_00000003
2_000_00ff_00000003
2_000_0100_00000001
f_000_0000_00000000

// File: compile.f
design/arithCodecPkg.sv
design/bitStreamIf.sv
design/seqDivider.sv
design/freqModel.sv
design/intervalCoder.sv
design/bitPacker.sv
design/encoderControl.sv
design/arithEncoder.sv
testbench/tbArithEncoder.sv

// File: run.sh
#!/bin/sh
# builds and runs the encoder testbench with Verilator
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert -f compile.f --top-module tbArithEncoder -o simTop
./obj_dir/simTop

// File: testbench/tbArithEncoder.sv
// testbench for arithEncoder; reads testbench/encoderInput.dat from the project root, max 256 entries
`timescale 1ns/1ps
`default_nettype none

module tbArithEncoder
    import arithCodecPkg::*;
;

    logic clk;
    logic rstn;
    logic start;
    symbol_t inputBits;
    logic newBitsProvided;
    logic readSuccess;
    logic idle;
    logic newBitsRequested;
    logic resultReady;
    byteCount_t validOutputBytes;
    word_t out;

    logic [63:0] fileMem [0:255]; // kind in [63:60], field in [47:32], value in [31:0]
    symbol_t msgSyms [$];
    word_t expWords [$];
    byteCount_t expBytes [$];
    int freq [numSymbols];
    logic [31:0] lcgState = 32'h79f6_27fe;
    word_t packWord;
    int packCount;

    arithEncoder arithEncoder_i (
        .clk, .rstn, .start, .inputBits, .newBitsProvided, .readSuccess,
        .idle, .newBitsRequested, .resultReady, .validOutputBytes, .out
    );

    initial clk = 1'b0;
    always #5 clk = ~clk;

    function automatic int nextDelay(bit useDelays);
        lcgState = lcgState * 32'd1664525 + 32'd1013904223;
        return useDelays ? int'(lcgState[18:16]) : 0; // 0 to 7 cycles
    endfunction

    task automatic stepCycle();
        @(posedge clk);
        #1;
    endtask

    task automatic watchdog(int cycles);
        repeat (cycles) @(posedge clk);
        $display("watchdog expired, the encoder stopped making progress");
        $display("Something failed");
        $fatal(1, "timeout");
    endtask

    task automatic checkWord(string name, word_t got, word_t exp);
        if (got !== exp) begin
            $display("ERROR at %0t: %s is %h, expected %h", $time, name, got, exp);
            $display("Something failed");
            $fatal(1, "word mismatch");
        end
    endtask

    task automatic checkBytes(string name, byteCount_t got, byteCount_t exp);
        if (got !== exp) begin
            $display("ERROR at %0t: %s is %0d, expected %0d", $time, name, got, exp);
            $display("Something failed");
            $fatal(1, "byte count mismatch");
        end
    endtask

    task automatic checkFlag(string name, logic got, logic exp);
        if (got !== exp) begin
            $display("ERROR at %0t: %s is %b, expected %b", $time, name, got, exp);
            $display("Something failed");
            $fatal(1, "flag mismatch");
        end
    endtask

    task automatic emitBit(bit value);
        packWord[packCount] = value; // words fill from bit 0
        packCount++;
        if (packCount == wordBits) begin
            expWords.push_back(packWord);
            expBytes.push_back(byteCount_t'(4));
            packWord = '0;
            packCount = 0;
        end
    endtask

    // reference coder straight from the arithmetic coding rule
    task automatic modelMessage();
        int a;
        int b;
        int s;
        int w;
        int cl;
        int ch;
        int totalF;
        bit done;
        a = 0;
        b = wholeRange;
        s = 0;
        totalF = numSymbols;
        packWord = '0;
        packCount = 0;
        for (int i = 0; i < numSymbols; i++) freq[i] = 1;
        foreach (msgSyms[n]) begin
            cl = 0;
            for (int i = 0; i < int'(msgSyms[n]); i++) cl += freq[i];
            ch = cl + freq[msgSyms[n]];
            w = b - a;
            b = a + (w * ch) / totalF;
            a = a + (w * cl) / totalF;
            done = 1'b0;
            while (!done) begin
                if (b < halfRange || a > halfRange) begin
                    emitBit(a > halfRange);
                    repeat (s) emitBit(!(a > halfRange));
                    s = 0;
                    if (a > halfRange) begin
                        a -= halfRange;
                        b -= halfRange;
                    end
                    a *= 2;
                    b *= 2;
                end else if (a > quarterRange && b < threeQuarters) begin
                    s++;
                    a = 2 * (a - quarterRange);
                    b = 2 * (b - quarterRange);
                end else begin
                    done = 1'b1;
                end
            end
            if (int'(msgSyms[n]) == eofSymbol) begin
                emitBit(a > quarterRange);
                repeat (s + 1) emitBit(!(a > quarterRange));
            end else begin
                if (totalF == freqLimit) begin
                    totalF = 0;
                    for (int i = 0; i < numSymbols; i++) begin
                        if (freq[i] > 1) freq[i] = freq[i] / 2;
                        totalF += freq[i];
                    end
                end
                freq[msgSyms[n]]++;
                totalF++;
            end
        end
        if (packCount > 0) begin
            expWords.push_back(packWord);
            expBytes.push_back(byteCount_t'((packCount + 7) / 8));
        end
    endtask

    task automatic feedSymbols(bit useDelays);
        for (int n = 1; n < msgSyms.size(); n++) begin
            while (!newBitsRequested) stepCycle();
            repeat (nextDelay(useDelays)) stepCycle();
            inputBits = msgSyms[n];
            newBitsProvided = 1'b1;
            while (newBitsRequested) stepCycle();
            newBitsProvided = 1'b0;
        end
    endtask

    task automatic readWords(bit useDelays);
        for (int n = 0; n < expWords.size(); n++) begin
            while (!resultReady) stepCycle();
            repeat (nextDelay(useDelays)) stepCycle();
            checkWord("out", out, expWords[n]);
            checkBytes("validOutputBytes", validOutputBytes, expBytes[n]);
            readSuccess = 1'b1;
            while (resultReady) stepCycle();
            readSuccess = 1'b0;
        end
    endtask

    task automatic runMessage(bit useDelays);
        int waitCycles;
        while (!idle) stepCycle();
        inputBits = msgSyms[0]; // first symbol rides on start
        start = 1'b1;
        stepCycle();
        start = 1'b0;
        fork
            feedSymbols(useDelays);
            readWords(useDelays);
        join
        waitCycles = 0;
        while (!idle && !resultReady && waitCycles < 200) begin // final flush, then idle
            stepCycle();
            waitCycles++;
        end
        if (resultReady) begin
            $display("the encoder presented more words than expected");
            $display("Something failed");
            $fatal(1, "extra word");
        end
        checkFlag("idle", idle, 1'b1);
    endtask

    initial begin
        int idx;
        int symbolTotal;
        bit useDelays;
        start = 1'b0;
        inputBits = '0;
        newBitsProvided = 1'b0;
        readSuccess = 1'b0;
        rstn = 1'b0;
        for (int i = 0; i < 256; i++) fileMem[i] = {4'hf, 28'h0, 32'(i)}; // end marker everywhere
        $readmemh("testbench/encoderInput.dat", fileMem);
        symbolTotal = 0;
        for (int i = 0; i < 256; i++) begin
            if (fileMem[i][63:60] == 4'h2) symbolTotal += int'(fileMem[i][31:0]);
        end
        fork
            watchdog(200 * symbolTotal + 10000);
        join_none
        repeat (8) @(posedge clk);
        #1;
        rstn = 1'b1;
        stepCycle();
        checkFlag("idle", idle, 1'b1);
        checkFlag("resultReady", resultReady, 1'b0);
        checkFlag("newBitsRequested", newBitsRequested, 1'b0);
        idx = 0;
        while (fileMem[idx][63:60] == 4'h1) begin
            useDelays = fileMem[idx][32];
            idx++;
            msgSyms.delete();
            expWords.delete();
            expBytes.delete();
            while (fileMem[idx][63:60] == 4'h2) begin
                repeat (int'(fileMem[idx][31:0])) begin
                    msgSyms.push_back(symbol_t'(fileMem[idx][40:32]));
                end
                idx++;
            end
            while (fileMem[idx][63:60] == 4'h3) begin
                expBytes.push_back(byteCount_t'(fileMem[idx][34:32]));
                expWords.push_back(fileMem[idx][31:0]);
                idx++;
            end
            if (expWords.size() == 0) modelMessage(); // no listed words, use the reference coder
            $display("message of %0d symbols, %0d words", msgSyms.size(), expWords.size());
            runMessage(useDelays);
        end
        $display("Everything OK");
        $finish;
    end

endmodule

`default_nettype wire

// File: design/arithEncoder.sv
// adaptive arithmetic encoder top; symbols 0 to 256 only, 256 ends the message
`timescale 1ns/1ps
`default_nettype none

module arithEncoder
    import arithCodecPkg::*;
(
    input  wire logic    clk,
    input  wire logic    rstn,
    input  wire logic    start,
    input  wire symbol_t inputBits,
    input  wire logic    newBitsProvided,
    input  wire logic    readSuccess,
    output logic         idle,
    output logic         newBitsRequested,
    output logic         resultReady,
    output byteCount_t   validOutputBytes,
    output word_t        out
);

    symbol_t symbol;
    freq_t cumLow, cumHigh, total;
    logic clear, codeStart, lastSymbol, modelUpdate, modelBusy, codeDone;

    bitStreamIf bitLink ();

    encoderControl control_i (
        .clk, .rstn, .start, .inputBits, .newBitsProvided, .modelBusy, .codeDone,
        .flushDone(bitLink.flushDone),
        .idle, .newBitsRequested, .symbol, .clear, .codeStart, .lastSymbol, .modelUpdate
    );

    freqModel model_i (
        .clk, .rstn, .clear, .symbol, .modelUpdate, .cumLow, .cumHigh, .total, .modelBusy
    );

    intervalCoder coder_i (
        .clk, .rstn, .clear, .codeStart, .lastSymbol, .cumLow, .cumHigh, .total, .codeDone,
        .bits(bitLink.coder)
    );

    bitPacker packer_i (
        .clk, .rstn, .readSuccess, .resultReady, .validOutputBytes, .out,
        .bits(bitLink.packer)
    );

endmodule

`default_nettype wire

// File: design/encoderControl.sv
// message sequencing; the first symbol comes with start, later ones through the request handshake
`timescale 1ns/1ps
`default_nettype none

module encoderControl
    import arithCodecPkg::*;
(
    input  wire logic    clk,
    input  wire logic    rstn,
    input  wire logic    start,
    input  wire symbol_t inputBits,
    input  wire logic    newBitsProvided,
    input  wire logic    modelBusy,
    input  wire logic    codeDone,
    input  wire logic    flushDone,
    output logic         idle,
    output logic         newBitsRequested,
    output symbol_t      symbol,
    output logic         clear,
    output logic         codeStart,
    output logic         lastSymbol,
    output logic         modelUpdate
);

    typedef enum logic [2:0] {
        ctrlIdle, startCode, coding, updateModel, modelWait, requestNext, providedWait
    } ctrlState_t;

    ctrlState_t state;

    assign idle = (state == ctrlIdle);
    assign clear = (state == ctrlIdle); // model and interval back to uniform between messages
    assign codeStart = (state == startCode);
    assign modelUpdate = (state == updateModel);
    assign newBitsRequested = (state == requestNext);
    assign lastSymbol = (symbol == symbol_t'(eofSymbol));

    always_ff @(posedge clk) begin
        if (!rstn) begin
            state <= ctrlIdle;
        end else begin
            case (state)
                ctrlIdle: if (start) state <= startCode;
                startCode: state <= coding;
                coding: begin
                    if (lastSymbol && flushDone) begin
                        state <= ctrlIdle; // final word read
                    end else if (!lastSymbol && codeDone) begin
                        state <= updateModel;
                    end
                end
                updateModel: state <= modelWait;
                modelWait: if (!modelBusy) state <= requestNext;
                requestNext: if (newBitsProvided) state <= providedWait;
                default: if (!newBitsProvided) state <= startCode;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if ((state == ctrlIdle && start) || (state == requestNext && newBitsProvided)) begin
            symbol <= inputBits;
        end
    end

endmodule

`default_nettype wire

// File: design/bitPacker.sv
// packs bits from bit 0 upward into 32-bit words; partial words only at a flush, unused bits read as 0
`timescale 1ns/1ps
`default_nettype none

module bitPacker
    import arithCodecPkg::*;
(
    input  wire logic  clk,
    input  wire logic  rstn,
    input  wire logic  readSuccess,
    output logic       resultReady,
    output byteCount_t validOutputBytes,
    output word_t      out,
    bitStreamIf.packer bits
);

    typedef enum logic [1:0] {collect, present, waitRelease} packState_t;

    packState_t state;
    logic [$clog2(wordBits)-1:0] bitPos;
    logic lastWord; // presented word closes the message

    assign resultReady = (state == present);
    assign bits.wordFull = (state != collect);
    assign bits.flushDone = (state == waitRelease && !readSuccess && lastWord)
                            || (state == collect && bits.flush && bitPos == '0);

    always_ff @(posedge clk) begin
        if (!rstn) begin
            state <= collect;
            bitPos <= '0;
            out <= '0;
            validOutputBytes <= '0;
            lastWord <= 1'b0;
        end else begin
            case (state)
                collect: begin
                    if (bits.bitValid) begin
                        out[bitPos] <= bits.bitValue;
                        bitPos <= bitPos + 1'b1; // wraps to 0 on a full word
                        if (int'(bitPos) == wordBits - 1) begin
                            validOutputBytes <= byteCount_t'(wordBits / 8);
                            lastWord <= 1'b0;
                            state <= present;
                        end
                    end else if (bits.flush && bitPos != '0) begin
                        validOutputBytes <= byteCount_t'((int'(bitPos) + 7) / 8); // started bytes
                        lastWord <= 1'b1;
                        state <= present;
                    end
                end
                present: begin
                    if (readSuccess) begin
                        out <= '0;
                        bitPos <= '0;
                        state <= waitRelease;
                    end
                end
                default: if (!readSuccess) state <= collect;
            endcase
        end
    end

    noBitWhileFull: assert property (@(posedge clk) disable iff (!rstn)
        (bits.bitValid || bits.flush) |-> !bits.wordFull);

endmodule

`default_nettype wire

// File: design/intervalCoder.sv
// narrows [a, b) per symbol and rescales; cumulative bounds and lastSymbol must hold until codeDone
`timescale 1ns/1ps
`default_nettype none

module intervalCoder
    import arithCodecPkg::*;
(
    input  wire logic  clk,
    input  wire logic  rstn,
    input  wire logic  clear,
    input  wire logic  codeStart,
    input  wire logic  lastSymbol,
    input  wire freq_t cumLow,
    input  wire freq_t cumHigh,
    input  wire freq_t total,
    output logic       codeDone,
    bitStreamIf.coder  bits
);

    typedef enum logic [2:0] {
        coderIdle, divHigh, divLow, rescale, emitPending, emitLast, emitFlush
    } coderState_t;

    coderState_t state;
    bound_t a, b, w;
    pending_t s;
    product_t dividend, lowProduct, quotient;
    logic divStart, divDone;
    logic oppBit;  // value of the deferred bits
    logic tail;    // deferred bits close the message
    logic lowerHalf, upperHalf, middle;

    assign w = b - a;
    assign lowerHalf = b < halfRange;
    assign upperHalf = a > halfRange;
    assign middle = a > quarterRange && b < threeQuarters;

    seqDivider divider_i (
        .clk,
        .rstn,
        .divStart,
        .dividend,
        .divisor(total),
        .quotient,
        .divDone
    );

    assign bits.bitValid = !bits.wordFull && ((state == rescale && (lowerHalf || upperHalf))
                           || state == emitPending || state == emitLast);
    assign bits.bitValue = (state == emitPending) ? oppBit
                         : (state == emitLast) ? (a > quarterRange) : !lowerHalf;
    assign bits.flush = !bits.wordFull && state == emitFlush;

    always_ff @(posedge clk) begin
        if (!rstn) begin
            state <= coderIdle;
            divStart <= 1'b0;
            codeDone <= 1'b0;
        end else begin
            divStart <= 1'b0;
            codeDone <= 1'b0;
            case (state)
                coderIdle: begin
                    if (codeStart) begin
                        divStart <= 1'b1; // upper bound first
                        state <= divHigh;
                    end
                end
                divHigh: begin
                    if (divDone) begin
                        divStart <= 1'b1;
                        state <= divLow;
                    end
                end
                divLow: if (divDone) state <= rescale;
                rescale: begin
                    if (!bits.wordFull) begin
                        if (!(lowerHalf || upperHalf || middle)) begin
                            if (lastSymbol) begin
                                state <= emitLast;
                            end else begin
                                codeDone <= 1'b1;
                                state <= coderIdle;
                            end
                        end else if ((lowerHalf || upperHalf) && s != '0) begin
                            state <= emitPending;
                        end
                    end
                end
                emitPending: begin
                    if (!bits.wordFull && s == pending_t'(1)) begin
                        state <= tail ? emitFlush : rescale;
                    end
                end
                emitLast: if (!bits.wordFull) state <= emitPending;
                default: if (!bits.wordFull) state <= coderIdle; // flush sent
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (clear) begin
            a <= '0;
            b <= bound_t'(wholeRange);
            s <= '0;
            tail <= 1'b0;
        end else begin
            case (state)
                coderIdle: begin
                    if (codeStart) begin
                        dividend <= product_t'(w) * cumHigh;
                        lowProduct <= product_t'(w) * cumLow;
                    end
                end
                divHigh: begin
                    if (divDone) begin
                        b <= a + bound_t'(quotient); // a still holds the old start
                        dividend <= lowProduct;
                    end
                end
                divLow: if (divDone) a <= a + bound_t'(quotient);
                rescale: begin
                    if (!bits.wordFull) begin
                        if (lowerHalf) begin
                            a <= a << 1;
                            b <= b << 1;
                            oppBit <= 1'b1;
                        end else if (upperHalf) begin
                            a <= bound_t'((a - halfRange) << 1);
                            b <= bound_t'((b - halfRange) << 1);
                            oppBit <= 1'b0;
                        end else if (middle) begin
                            a <= bound_t'((a - quarterRange) << 1);
                            b <= bound_t'((b - quarterRange) << 1);
                            s <= s + 1'b1;
                        end
                    end
                end
                emitPending: if (!bits.wordFull) s <= s - 1'b1;
                emitLast: begin
                    if (!bits.wordFull) begin
                        s <= s + 1'b1; // s + 1 opposite bits end the message
                        oppBit <= (a <= quarterRange);
                        tail <= 1'b1;
                    end
                end
                default: ;
            endcase
        end
    end

    intervalOrdered: assert property (@(posedge clk) disable iff (!rstn || clear)
        state == rescale |-> a < b);

endmodule

`default_nettype wire

// File: design/freqModel.sv
// adaptive symbol model; symbol must stay stable while modelBusy is high, halving takes 259 cycles
`timescale 1ns/1ps
`default_nettype none

module freqModel
    import arithCodecPkg::*;
(
    input  wire logic    clk,
    input  wire logic    rstn,
    input  wire logic    clear,
    input  wire symbol_t symbol,
    input  wire logic    modelUpdate,
    output freq_t        cumLow,
    output freq_t        cumHigh,
    output freq_t        total,
    output logic         modelBusy
);

    typedef enum logic [1:0] {waitUpdate, rebuild, applyInc} modelState_t;

    modelState_t state;
    freq_t count [numSymbols];
    freq_t lowBound [numSymbols]; // cumulative bound below each symbol
    freq_t runSum;
    symbol_t walkIdx;
    logic bump;

    assign cumLow = lowBound[symbol];
    assign cumHigh = lowBound[symbol] + count[symbol];
    assign modelBusy = (state != waitUpdate);
    assign bump = (state == waitUpdate && modelUpdate && total != freq_t'(freqLimit))
                  || state == applyInc;

    always_ff @(posedge clk) begin
        if (!rstn || clear) begin
            state <= waitUpdate;
        end else begin
            case (state)
                waitUpdate: if (modelUpdate && total == freq_t'(freqLimit)) state <= rebuild;
                rebuild: if (walkIdx == symbol_t'(numSymbols - 1)) state <= applyInc;
                default: state <= waitUpdate;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (clear) begin
            for (int i = 0; i < numSymbols; i++) begin
                count[i] <= freq_t'(1);
                lowBound[i] <= freq_t'(i);
            end
            total <= freq_t'(numSymbols);
        end else if (bump) begin
            count[symbol] <= count[symbol] + 1'b1;
            for (int i = 0; i < numSymbols; i++) begin
                if (i > int'(symbol)) begin
                    lowBound[i] <= lowBound[i] + 1'b1;
                end
            end
            total <= (state == applyInc) ? runSum + 1'b1 : total + 1'b1;
        end else if (state == waitUpdate && modelUpdate) begin
            // total hit the limit, keep every count at one or more
            for (int i = 0; i < numSymbols; i++) begin
                if (count[i] != freq_t'(1)) begin
                    count[i] <= count[i] >> 1;
                end
            end
            walkIdx <= '0;
            runSum <= '0;
        end else if (state == rebuild) begin
            lowBound[walkIdx] <= runSum;
            runSum <= runSum + count[walkIdx];
            walkIdx <= walkIdx + 1'b1;
        end
    end

    boundsOrdered: assert property (@(posedge clk) disable iff (!rstn || clear)
        !modelBusy |-> (cumLow < cumHigh) && (cumHigh <= total));

endmodule

`default_nettype wire

// File: design/seqDivider.sv
// restoring divider, one quotient bit per cycle; divDone comes 28 cycles after divStart, divisor nonzero
`timescale 1ns/1ps
`default_nettype none

module seqDivider
    import arithCodecPkg::*;
(
    input  wire logic     clk,
    input  wire logic     rstn,
    input  wire logic     divStart,
    input  wire product_t dividend,
    input  wire freq_t    divisor,
    output product_t      quotient,
    output logic          divDone
);

    localparam int steps = $bits(product_t);

    freq_t divisorReg;
    freq_t remainder;
    logic [4:0] stepsLeft;
    logic busy;
    logic [$bits(freq_t):0] trial;

    assign trial = {remainder, quotient[steps-1]}; // next dividend bit shifted in

    always_ff @(posedge clk) begin
        if (!rstn) begin
            busy <= 1'b0;
            divDone <= 1'b0;
            stepsLeft <= '0;
        end else begin
            divDone <= 1'b0;
            if (divStart) begin
                busy <= 1'b1;
                stepsLeft <= 5'(steps);
            end else if (busy) begin
                stepsLeft <= stepsLeft - 5'd1;
                if (stepsLeft == 5'd1) begin
                    busy <= 1'b0;
                    divDone <= 1'b1; // last quotient bit lands on this edge
                end
            end
        end
    end

    // quotient bits replace dividend bits from the bottom
    always_ff @(posedge clk) begin
        if (divStart) begin
            quotient <= dividend;
            remainder <= '0;
            divisorReg <= divisor;
        end else if (busy) begin
            if (trial >= {1'b0, divisorReg}) begin
                remainder <= freq_t'(trial - {1'b0, divisorReg});
                quotient <= {quotient[steps-2:0], 1'b1};
            end else begin
                remainder <= freq_t'(trial);
                quotient <= {quotient[steps-2:0], 1'b0};
            end
        end
    end

    divisorNonZero: assert property (@(posedge clk) disable iff (!rstn)
        divStart |-> divisor != '0);

endmodule

`default_nettype wire

// File: design/bitStreamIf.sv
// coded bits from interval coder to packer; the coder must not send a bit or a flush while wordFull is high
`timescale 1ns/1ps
`default_nettype none

interface bitStreamIf;

    logic bitValid;  // one bit per pulse
    logic bitValue;
    logic flush;     // pulse after the final bit of a message
    logic wordFull;  // a word is out and not yet read
    logic flushDone; // last word of the message has been read

    modport coder (
        output bitValid,
        output bitValue,
        output flush,
        input  wordFull
    );

    modport packer (
        input  bitValid,
        input  bitValue,
        input  flush,
        output wordFull,
        output flushDone
    );

endinterface

`default_nettype wire

// File: design/arithCodecPkg.sv
// coder constants and types for a 14-bit precision, 257-symbol encoder; widths change only with precision
`default_nettype none

package arithCodecPkg;

    localparam int precision = 14;
    localparam int numSymbols = 257;                  // bytes plus end of message
    localparam int eofSymbol = 256;

    localparam int wholeRange = 1 << (precision - 1); // 8192
    localparam int halfRange = wholeRange / 2;
    localparam int quarterRange = wholeRange / 4;
    localparam int threeQuarters = 3 * quarterRange;
    localparam int freqLimit = quarterRange - 1;      // total that starts a halving

    localparam int wordBits = 32;

    typedef logic [$clog2(numSymbols)-1:0] symbol_t;
    typedef logic [precision-4:0] freq_t;             // frequency or cumulative bound
    typedef logic [precision-1:0] bound_t;            // interval bound, holds wholeRange itself
    typedef logic [2*precision-2:0] product_t;        // width times bound, also the dividend
    typedef logic [6:0] pending_t;                    // deferred opposite bits
    typedef logic [wordBits-1:0] word_t;
    typedef logic [2:0] byteCount_t;

endpackage

`default_nettype wire
